//--- logic/display_pkg.sv
/* Shared widths, typedefs and the button FSM states for the seven-segment
   display design */
`default_nettype none

package display_pkg;

	// ####################
	// Display geometry
	// ####################

	localparam int NUM_DIGITS = 4;
	localparam int MSG_LEN    = 16;

	localparam int ANODE_W = 4;
	localparam int CHAR_W  = 4;
	localparam int SEG_W   = 7;

	// ####################
	// Types
	// ####################

	// Multiplex phase 0..15
	typedef logic [ANODE_W-1:0] anode_state_t;

	// One hex character of the message
	typedef logic [CHAR_W-1:0] char_t;

	// Active-low segments a to g with bit 0 as segment a
	typedef logic [SEG_W-1:0] seg_t;

	typedef enum logic [1:0]
	{
		BTN_IDLE,
		BTN_DEBOUNCE,
		BTN_HELD
	} btn_state_e;

endpackage

`default_nettype wire

//--- logic/refresh_timer.sv
/* Refresh timer with the prescaler and anode state counter for the display multiplex */
`default_nettype none

module refresh_timer
	import display_pkg::*;
#(
	parameter int REFRESH_DIV = 4
)
(
	input  logic         clk,
	input  logic         rst_n,
	output anode_state_t anode_state
);

	localparam int PRE_W = (REFRESH_DIV > 1) ? $clog2(REFRESH_DIV) : 1;

	logic [PRE_W-1:0] prescale;
	logic             at_wrap;

	assign at_wrap = (prescale == PRE_W'(REFRESH_DIV - 1));

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			prescale    <= '0;
			anode_state <= '0;
		end
		else if (at_wrap)
		begin
			prescale    <= '0;
			// Wraps from 15 to 0 by width
			anode_state <= anode_state + 1'b1;
		end
		else
		begin
			prescale <= prescale + 1'b1;
		end
	end

	a_phase_on_wrap : assert property (@(posedge clk) disable iff (!rst_n)
		(anode_state != $past(anode_state)) |-> $past(at_wrap))
		else $error("anode state moved without a prescaler wrap");

endmodule

`default_nettype wire

//--- logic/rotate_button_fsm.sv
/* Debounce FSM for the rotate button with one strobe per press */
`default_nettype none

module rotate_button_fsm
	import display_pkg::*;
#(
	parameter int DEBOUNCE_CYCLES = 8
)
(
	input  logic clk,
	input  logic rst_n,
	input  logic r_btn,
	output logic rotate
);

	localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

	btn_state_e       state;
	btn_state_e       state_nxt;
	logic [CNT_W-1:0] stable_cnt;
	logic [CNT_W-1:0] stable_cnt_nxt;
	logic             rotate_nxt;
	logic             last_sample;

	// Current high sample completes the debounce window
	assign last_sample = (stable_cnt == CNT_W'(DEBOUNCE_CYCLES - 1));

	// ####################
	// Next state
	// ####################

	always_comb
	begin
		state_nxt      = state;
		stable_cnt_nxt = stable_cnt;
		rotate_nxt     = 1'b0;

		case (state)
			BTN_IDLE:
			begin
				if (r_btn)
				begin
					if (last_sample)
					begin
						rotate_nxt = 1'b1;
						state_nxt  = BTN_HELD;
					end
					else
					begin
						stable_cnt_nxt = CNT_W'(1);
						state_nxt      = BTN_DEBOUNCE;
					end
				end
			end
			BTN_DEBOUNCE:
			begin
				if (!r_btn)
				begin
					// A bounce drops the press
					stable_cnt_nxt = '0;
					state_nxt      = BTN_IDLE;
				end
				else if (last_sample)
				begin
					stable_cnt_nxt = '0;
					rotate_nxt     = 1'b1;
					state_nxt      = BTN_HELD;
				end
				else
				begin
					stable_cnt_nxt = stable_cnt + 1'b1;
				end
			end
			BTN_HELD:
			begin
				if (!r_btn)
					state_nxt = BTN_IDLE;
			end
			default:
			begin
				stable_cnt_nxt = '0;
				state_nxt      = BTN_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state      <= BTN_IDLE;
			stable_cnt <= '0;
			rotate     <= 1'b0;
		end
		else
		begin
			state      <= state_nxt;
			stable_cnt <= stable_cnt_nxt;
			rotate     <= rotate_nxt;
		end
	end

	a_single_strobe : assert property (@(posedge clk) disable iff (!rst_n)
		rotate |=> !rotate)
		else $error("rotate strobe high for two cycles");

endmodule

`default_nettype wire

//--- logic/message_rotator.sv
/* Message register with the scroll offset that supplies the four window characters */
`default_nettype none

module message_rotator
	import display_pkg::*;
#(
	parameter logic [MSG_LEN*CHAR_W-1:0] MESSAGE = 64'hFEDC_BA98_7654_3210
)
(
	input  logic  clk,
	input  logic  rst_n,
	input  logic  rotate,
	output char_t char0,
	output char_t char1,
	output char_t char2,
	output char_t char3
);

	localparam int OFS_W = $clog2(MSG_LEN);

	logic [OFS_W-1:0] offset;

	// Character at (ofs + k) mod MSG_LEN
	function automatic char_t char_at(input logic [OFS_W-1:0] ofs, input int k);
		int idx;
		idx = (int'(ofs) + k) % MSG_LEN;
		return MESSAGE[idx*CHAR_W +: CHAR_W];
	endfunction

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			offset <= '0;
		else if (rotate)
		begin
			if (offset == OFS_W'(MSG_LEN - 1))
				offset <= '0;
			else
				offset <= offset + 1'b1;
		end
	end

	// ####################
	// Window
	// ####################

	assign char0 = char_at(offset, 0);
	assign char1 = char_at(offset, 1);
	assign char2 = char_at(offset, 2);
	assign char3 = char_at(offset, 3);

endmodule

`default_nettype wire

//--- logic/digit_driver.sv
/* Digit driver that turns the anode state into active-low anode enables and picks
   the character for the digit being set up or lit */
`default_nettype none

module digit_driver
	import display_pkg::*;
(
	input  anode_state_t anode_state,
	input  char_t        char0,
	input  char_t        char1,
	input  char_t        char2,
	input  char_t        char3,
	output char_t        char_sel,
	output logic         an0,
	output logic         an1,
	output logic         an2,
	output logic         an3
);

	logic [1:0]            digit;
	logic [NUM_DIGITS-1:0] an_n;

	assign digit = anode_state[3:2];

	// ####################
	// Character select
	// ####################

	always_comb
	begin
		if (anode_state == 4'hF)
		begin
			// Blank last phase sets up digit 0 again
			char_sel = char0;
		end
		else
		begin
			case (digit)
				2'd0:    char_sel = char0;
				2'd1:    char_sel = char1;
				2'd2:    char_sel = char2;
				default: char_sel = char3;
			endcase
		end
	end

	// ####################
	// Anode enables
	// ####################

	// Character stable two phases before the anode turns on
	always_comb
	begin
		an_n = '1;
		if (anode_state[1:0] == 2'd2)
			an_n[digit] = 1'b0;
	end

	assign an0 = an_n[0];
	assign an1 = an_n[1];
	assign an2 = an_n[2];
	assign an3 = an_n[3];

	a_one_anode : assert final ($countones(an_n) >= NUM_DIGITS - 1)
		else $error("more than one anode driven low");

endmodule

`default_nettype wire

//--- logic/seg_decoder.sv
/* Hex character to active-low seven-segment pattern */
`default_nettype none

module seg_decoder
	import display_pkg::*;
(
	input  char_t char_sel,
	output seg_t  seg
);

	// Patterns are gfedcba where a 0 lights the segment
	always_comb
	begin
		case (char_sel)
			4'h0:    seg = 7'b100_0000;
			4'h1:    seg = 7'b111_1001;
			4'h2:    seg = 7'b010_0100;
			4'h3:    seg = 7'b011_0000;
			4'h4:    seg = 7'b001_1001;
			4'h5:    seg = 7'b001_0010;
			4'h6:    seg = 7'b000_0010;
			4'h7:    seg = 7'b111_1000;
			4'h8:    seg = 7'b000_0000;
			4'h9:    seg = 7'b001_0000;
			// Letters A b C d E F
			4'hA:    seg = 7'b000_1000;
			4'hB:    seg = 7'b000_0011;
			4'hC:    seg = 7'b100_0110;
			4'hD:    seg = 7'b010_0001;
			4'hE:    seg = 7'b000_0110;
			4'hF:    seg = 7'b000_1110;
			default: seg = 7'b111_1111;
		endcase
	end

endmodule

`default_nettype wire

//--- logic/display_top.sv
/* Display top level with the refresh timer, button FSM, message rotator, digit driver
   and segment decoder */
`default_nettype none

module display_top
	import display_pkg::*;
#(
	parameter int                        REFRESH_DIV     = 4,
	parameter int                        DEBOUNCE_CYCLES = 8,
	parameter logic [MSG_LEN*CHAR_W-1:0] MESSAGE         = 64'hFEDC_BA98_7654_3210
)
(
	input  logic clk,
	input  logic rst_n,
	input  logic r_btn,
	output logic an0,
	output logic an1,
	output logic an2,
	output logic an3,
	output seg_t seg
);

	anode_state_t anode_state;
	logic         rotate;
	char_t        char0;
	char_t        char1;
	char_t        char2;
	char_t        char3;
	char_t        char_sel;

	refresh_timer #(
		.REFRESH_DIV(REFRESH_DIV)
	) i_refresh_timer (
		.clk        (clk),
		.rst_n      (rst_n),
		.anode_state(anode_state)
	);

	rotate_button_fsm #(
		.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
	) i_rotate_button_fsm (
		.clk   (clk),
		.rst_n (rst_n),
		.r_btn (r_btn),
		.rotate(rotate)
	);

	message_rotator #(
		.MESSAGE(MESSAGE)
	) i_message_rotator (
		.clk   (clk),
		.rst_n (rst_n),
		.rotate(rotate),
		.char0 (char0),
		.char1 (char1),
		.char2 (char2),
		.char3 (char3)
	);

	digit_driver i_digit_driver (
		.anode_state(anode_state),
		.char0      (char0),
		.char1      (char1),
		.char2      (char2),
		.char3      (char3),
		.char_sel   (char_sel),
		.an0        (an0),
		.an1        (an1),
		.an2        (an2),
		.an3        (an3)
	);

	seg_decoder i_seg_decoder (
		.char_sel(char_sel),
		.seg     (seg)
	);

endmodule

`default_nettype wire

//--- bench/display_checker.sv
/* Display checker with the offset and phase model, reference segment function
   and the compare process */
`default_nettype none

module display_checker
	import display_pkg::*;
#(
	parameter int                        REFRESH_DIV     = 4,
	parameter int                        DEBOUNCE_CYCLES = 8,
	parameter logic [MSG_LEN*CHAR_W-1:0] MESSAGE         = 64'hFEDC_BA98_7654_3210
)
(
	input wire logic clk,
	input wire logic rst_n,
	input wire logic r_btn,
	input wire logic an0,
	input wire logic an1,
	input wire logic an2,
	input wire logic an3,
	input wire seg_t seg
);
	timeunit 1ns;
	timeprecision 1ps;

	// Lit segments as gfedcba with entry 0 in the low bits
	localparam logic [16*7-1:0] HEX_LIT = {
		7'h71, 7'h79, 7'h5E, 7'h39, 7'h7C, 7'h77, 7'h6F, 7'h7F,
		7'h07, 7'h7D, 7'h6D, 7'h66, 7'h4F, 7'h5B, 7'h06, 7'h3F
	};

	int         cycles;
	int         run;
	bit         held;
	bit         pend;
	int         model_offset;
	int         phase;
	int         err_count;
	int         lit_checks;
	logic [3:0] an_exp;

	function automatic seg_t expected_seg(input int ofs, input int digit);
		int c;
		c = MESSAGE[((ofs + digit) % MSG_LEN) * CHAR_W +: CHAR_W];
		return ~HEX_LIT[c*7 +: 7];
	endfunction

	initial
	begin
		err_count  = 0;
		lit_checks = 0;
	end

	// Debounce rule and offset model with one step per press
	always @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cycles       = 0;
			run          = 0;
			held         = 1'b0;
			pend         = 1'b0;
			model_offset = 0;
		end
		else
		begin
			cycles++;
			if (pend)
			begin
				model_offset = (model_offset + 1) % MSG_LEN;
				pend         = 1'b0;
			end
			if (!r_btn)
			begin
				run  = 0;
				held = 1'b0;
			end
			else if (!held)
			begin
				run++;
				if (run == DEBOUNCE_CYCLES)
				begin
					pend = 1'b1;
					held = 1'b1;
				end
			end
		end
	end

	always @(negedge clk)
	begin
		if (rst_n)
		begin
			phase  = (cycles / REFRESH_DIV) % 16;
			an_exp = 4'hF;
			if (phase % 4 == 2)
				an_exp[phase/4] = 1'b0;
			if ({an3, an2, an1, an0} !== an_exp)
			begin
				err_count++;
				$display("[FAIL] %0t: anodes %b in phase %0d, expected %b",
					$time, {an3, an2, an1, an0}, phase, an_exp);
			end
			else if (an_exp != 4'hF)
			begin
				lit_checks++;
				if (seg !== expected_seg(model_offset, phase / 4))
				begin
					err_count++;
					$display("[FAIL] %0t: digit %0d seg %b, expected %b at offset %0d",
						$time, phase / 4, seg, expected_seg(model_offset, phase / 4),
						model_offset);
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- bench/tb_display.sv
/* Testbench top with clock, reset, rotate button stimulus, DUT and checker instances
   and the closing report */
`default_nettype none

module tb_display
	import display_pkg::*;
;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int                        REFRESH_DIV     = 4;
	localparam int                        DEBOUNCE_CYCLES = 8;
	localparam logic [MSG_LEN*CHAR_W-1:0] MESSAGE         = 64'hFEDC_BA98_7654_3210;
	localparam int                        FRAME           = 16 * REFRESH_DIV;

	logic clk;
	logic rst_n;
	logic r_btn;
	logic an0;
	logic an1;
	logic an2;
	logic an3;
	seg_t seg;
	int   presses;

	always #5 clk = ~clk;

	display_top #(
		.REFRESH_DIV    (REFRESH_DIV),
		.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES),
		.MESSAGE        (MESSAGE)
	) i_dut (
		.clk  (clk),
		.rst_n(rst_n),
		.r_btn(r_btn),
		.an0  (an0),
		.an1  (an1),
		.an2  (an2),
		.an3  (an3),
		.seg  (seg)
	);

	display_checker #(
		.REFRESH_DIV    (REFRESH_DIV),
		.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES),
		.MESSAGE        (MESSAGE)
	) i_chk (
		.clk  (clk),
		.rst_n(rst_n),
		.r_btn(r_btn),
		.an0  (an0),
		.an1  (an1),
		.an2  (an2),
		.an3  (an3),
		.seg  (seg)
	);

	// High for hi_len cycles and then low for lo_len cycles
	task automatic press_button(input int hi_len, input int lo_len);
		r_btn = 1'b1;
		repeat (hi_len) @(negedge clk);
		r_btn = 1'b0;
		repeat (lo_len) @(negedge clk);
		if (hi_len >= DEBOUNCE_CYCLES)
			presses++;
	endtask

	// Model offset must reach the number of full presses
	task automatic wait_window_step();
		int n;
		n = 0;
		while (i_chk.model_offset != presses % MSG_LEN)
		begin
			@(negedge clk);
			n++;
			if (n > 4 * DEBOUNCE_CYCLES)
			begin
				$display("Timeout waiting for the window to reach offset %0d",
					presses % MSG_LEN);
				$display("Test failures found");
				$finish;
			end
		end
	endtask

	initial
	begin
		clk      = 1'b0;
		rst_n    = 1'b0;
		r_btn    = 1'b0;
		presses  = 0;
		void'($urandom(25431));
		repeat (5) @(negedge clk);
		rst_n = 1'b1;

		// ####################
		// Idle, clean and held presses
		// ####################
		repeat (2 * FRAME) @(negedge clk);
		press_button(DEBOUNCE_CYCLES + 4, 10);
		wait_window_step();
		press_button(4 * FRAME, 10);
		wait_window_step();

		// Bounces shorter than the debounce window
		repeat (20)
		begin
			press_button(1 + $urandom % (DEBOUNCE_CYCLES - 1), 1 + $urandom % 4);
			wait_window_step();
		end

		// Wrap the offset with every window shown for a full frame
		repeat (17)
		begin
			press_button(DEBOUNCE_CYCLES + 2, FRAME + $urandom % FRAME);
			wait_window_step();
		end

		// ####################
		// Random run
		// ####################
		repeat (60)
		begin
			press_button(1 + $urandom % (2 * DEBOUNCE_CYCLES), 1 + $urandom % 40);
			wait_window_step();
		end
		repeat (2 * FRAME) @(negedge clk);

		$display("Errors: %0d, lit cycles checked: %0d, presses: %0d",
			i_chk.err_count, i_chk.lit_checks, presses);
		if (i_chk.err_count == 0 && i_chk.lit_checks > 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
logic/display_pkg.sv
logic/refresh_timer.sv
logic/rotate_button_fsm.sv
logic/message_rotator.sv
logic/digit_driver.sv
logic/seg_decoder.sv
logic/display_top.sv
bench/display_checker.sv
bench/tb_display.sv

//--- Bender.yml
package:
  name: seven_seg_display

sources:
  - logic/display_pkg.sv
  - logic/refresh_timer.sv
  - logic/rotate_button_fsm.sv
  - logic/message_rotator.sv
  - logic/digit_driver.sv
  - logic/seg_decoder.sv
  - logic/display_top.sv
  - target: simulation
    files:
      - bench/display_checker.sv
      - bench/tb_display.sv
